/* verilog.f */
hw/uart_pkg.sv
hw/byte_fifo.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_regs.sv
hw/echo_ctrl.sv
hw/uart_echo_top.sv
dv/uart_echo_tb.sv

/* run.sh */
#!/bin/sh
# build the uart echo testbench with Verilator and run it
# the exit status of the simulation tells pass or fail
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -Wno-fatal -f verilog.f \
        --top-module uart_echo_tb -o uart_echo_sim &&
    ./obj_dir/uart_echo_sim || exit 1

/* dv/uart_echo_tb.sv */
// testbench for the uart echo top level with serial driver, serial monitor, stimulus table, watchdog
`timescale 1ns/1ps
`default_nettype none

module uart_echo_tb;

    localparam int     CLK_PERIOD   = 8;
    localparam int     BIT_CYCLES   = 8;
    localparam int     DELAY_CYCLES = 40;
    localparam int     FRAME_CYCLES = 10 * BIT_CYCLES;
    localparam int     POLL_MARGIN  = 40;     // status polling and bus accesses
    localparam int     IDLE_CYCLES  = 32;
    localparam int     QUIET_CYCLES = FRAME_CYCLES + 2 * DELAY_CYCLES;
    localparam int     NUM_FIXED    = 3;
    localparam int     NUM_ENTRIES  = 6;
    localparam longint MIN_ECHO_NS  = 2 * DELAY_CYCLES * CLK_PERIOD;

    typedef struct packed {
        logic [2:0]      n_send;
        logic            bad_first;     // first frame gets a low stop bit
        logic [2:0]      n_exp;
        logic [3:0][7:0] send_bytes;
        logic [3:0][7:0] exp_bytes;
    } stim_t;

    logic       pll_clk    = 1'b0;
    logic       rst        = 1'b0;
    logic       rx_pin     = 1'b1;
    logic       tx_pin;
    logic       led;
    logic       stim_ready = 1'b0;
    integer     seed       = 32'hee48;
    stim_t      stim_tab [NUM_ENTRIES];
    logic [7:0] exp_q [$];
    logic [7:0] got_q [$];
    time        stop_end_q [$];     // end of each good received stop bit

    uart_echo_top #(
        .BAUD_DIV(BIT_CYCLES), .DELAY_CYCLES(DELAY_CYCLES), .FIFO_DEPTH(4)
    ) uart_echo_top_inst (
        .i_pll_clk(pll_clk), .i_rst(rst), .i_rx_pin(rx_pin), .o_tx_pin(tx_pin), .o_led(led)
    );

    always #(CLK_PERIOD / 2) pll_clk = ~pll_clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    function automatic stim_t make_entry(input int n_send, input logic bad_first,
                                         input int n_exp, input logic [3:0][7:0] send_bytes,
                                         input logic [3:0][7:0] exp_bytes);
        stim_t s;
        s.n_send     = 3'(n_send);
        s.bad_first  = bad_first;
        s.n_exp      = 3'(n_exp);
        s.send_bytes = send_bytes;
        s.exp_bytes  = exp_bytes;
        return s;
    endfunction

    task automatic fill_stim();
        logic [3:0][7:0] bytes;
        integer          rnd;
        int              e;
        int              k;
        stim_tab[0] = make_entry(1, 1'b0, 1, 32'h5a, 32'h5a);     // single byte
        stim_tab[1] = make_entry(4, 1'b0, 4, 32'h7ec32211, 32'h7ec32211);
        stim_tab[2] = make_entry(2, 1'b1, 1, 32'h3ca5, 32'h3c);   // bad frame then good
        for (e = NUM_FIXED; e < NUM_ENTRIES; e++) begin
            bytes = '0;
            for (k = 0; k < 3; k++) begin
                rnd      = $random(seed);
                bytes[k] = rnd[7:0];
            end
            stim_tab[e] = make_entry(3, 1'b0, 3, bytes, bytes);
        end
    endtask

    function automatic int total_frames();
        int sum;
        sum = 0;
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            sum += int'(stim_tab[e].n_send);
        end
        return sum;
    endfunction

    task automatic send_frame(input logic [7:0] data, input logic bad_stop);
        logic [9:0] bits;
        int         i;
        bits = {~bad_stop, data, 1'b0};     // stop, data lsb first, start
        for (i = 0; i < 10; i++) begin
            @(posedge pll_clk);
            rx_pin <= bits[i];
            repeat (BIT_CYCLES - 1) @(posedge pll_clk);
        end
        @(posedge pll_clk);
        rx_pin <= 1'b1;
        if (!bad_stop) begin
            stop_end_q.push_back($time);
        end
    endtask

    task automatic wait_gap();
        integer rnd;
        int     gap;
        rnd = $random(seed);
        gap = $unsigned(rnd) % (4 * BIT_CYCLES);    // under four bit periods
        repeat (gap) @(posedge pll_clk);
    endtask

    task automatic check_idle_lines();
        repeat (IDLE_CYCLES) begin
            @(negedge pll_clk);
            assert (tx_pin === 1'b1)
                else fail_run($sformatf("MISMATCH o_tx_pin expected %h got %h", 1'b1, tx_pin));
            assert (led === 1'b1)
                else fail_run($sformatf("MISMATCH o_led expected %h got %h", 1'b1, led));
        end
    endtask

    task automatic check_led_low();
        logic seen_low;
        seen_low = 1'b0;
        repeat (BIT_CYCLES) begin
            @(negedge pll_clk);
            if (led === 1'b0) begin
                seen_low = 1'b1;
            end
        end
        assert (seen_low)
            else fail_run($sformatf("MISMATCH o_led expected %h got %h", 1'b0, led));
    endtask

    initial begin : main_seq
        int exp_total;
        int e;
        int k;
        fill_stim();
        stim_ready = 1'b1;
        exp_total  = 0;
        repeat (3) @(posedge pll_clk);
        rst <= 1'b1;
        check_idle_lines();
        for (e = 0; e < NUM_ENTRIES; e++) begin
            for (k = 0; k < int'(stim_tab[e].n_exp); k++) begin
                exp_q.push_back(stim_tab[e].exp_bytes[k]);
            end
            exp_total += int'(stim_tab[e].n_exp);
            for (k = 0; k < int'(stim_tab[e].n_send); k++) begin
                if (k > 0) begin
                    wait_gap();
                end
                send_frame(stim_tab[e].send_bytes[k], stim_tab[e].bad_first && (k == 0));
            end
            check_led_low();      // last frame of an entry is always good
            while (got_q.size() < exp_total) begin
                @(negedge pll_clk);
            end
        end
        repeat (QUIET_CYCLES) @(negedge pll_clk);   // no stray echo afterwards
        $display("Everything OK");
        $finish;
    end

    initial begin : tx_monitor
        logic [7:0] data;
        logic [7:0] exp_byte;
        time        start_t;
        int         n;
        int         b;
        wait (rst === 1'b1);
        forever begin
            @(negedge pll_clk);
            if (tx_pin === 1'b0) begin
                start_t = $time;
                n       = got_q.size();
                assert (n < stop_end_q.size())
                    else fail_run("an echo frame started with no byte received");
                assert (start_t - stop_end_q[n] >= MIN_ECHO_NS)
                    else fail_run($sformatf("echo %0d started only %0d ns after its stop bit",
                                            n, start_t - stop_end_q[n]));
                repeat (BIT_CYCLES / 2) @(negedge pll_clk);    // middle of start bit
                for (b = 0; b < 8; b++) begin
                    repeat (BIT_CYCLES) @(negedge pll_clk);
                    data[b] = tx_pin;
                end
                repeat (BIT_CYCLES) @(negedge pll_clk);
                assert (tx_pin === 1'b1)
                    else fail_run("the stop bit of an echo frame on o_tx_pin was low");
                exp_byte = exp_q.pop_front();
                assert (data == exp_byte)
                    else fail_run($sformatf("MISMATCH tx_byte expected %h got %h",
                                            exp_byte, data));
                got_q.push_back(data);
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (stim_ready);
        limit = 2 * total_frames() * (FRAME_CYCLES + 2 * DELAY_CYCLES + POLL_MARGIN);
        repeat (limit) @(posedge pll_clk);
        fail_run("timeout, the echo did not arrive in time");
    end

endmodule

`default_nettype wire

/* hw/uart_echo_top.sv */
// uart echo top level with controller, register block, fifos, transmitter and receiver
`timescale 1ns/1ps
`default_nettype none

module uart_echo_top #(
    parameter int BAUD_DIV     = 469,
    parameter int DELAY_CYCLES = 6_750_000,
    parameter int FIFO_DEPTH   = 4
) (
    input  logic i_pll_clk,
    input  logic i_rst,
    input  logic i_rx_pin,
    output logic o_tx_pin,
    output logic o_led
);
    import uart_pkg::*;

    bus_req_t  bus_req;
    bus_rsp_t  bus_rsp;
    baud_div_t baud_div;
    byte_t     rx_byte;
    byte_t     rx_head;
    byte_t     tx_byte;
    byte_t     tx_head;
    logic      rx_strobe;
    logic      rx_empty;
    logic      rx_pop;
    logic      tx_push;
    logic      tx_full;
    logic      tx_empty;
    logic      tx_pop;
    logic      tx_drained;
    logic      irq;

    assign o_led = ~irq;    // led lit while an interrupt is pending

    echo_ctrl #(.BAUD_DIV(BAUD_DIV), .DELAY_CYCLES(DELAY_CYCLES)) echo_ctrl_inst (
        .i_pll_clk(i_pll_clk), .i_rst(i_rst), .o_req(bus_req), .i_rsp(bus_rsp)
    );

    uart_regs uart_regs_inst (
        .i_pll_clk(i_pll_clk), .i_rst(i_rst),
        .i_req(bus_req), .o_rsp(bus_rsp), .o_baud_div(baud_div),
        .i_rx_empty(rx_empty), .i_rx_byte(rx_head), .o_rx_pop(rx_pop),
        .i_tx_full(tx_full), .o_tx_push(tx_push), .o_tx_byte(tx_byte),
        .i_rx_strobe(rx_strobe), .i_tx_drained(tx_drained), .o_irq(irq)
    );

    byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rx_fifo_inst (
        .i_pll_clk(i_pll_clk), .i_rst(i_rst),
        .i_push(rx_strobe), .i_wdata(rx_byte), .i_pop(rx_pop), .o_rdata(rx_head),
        .o_empty(rx_empty), .o_full()
    );

    byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tx_fifo_inst (
        .i_pll_clk(i_pll_clk), .i_rst(i_rst),
        .i_push(tx_push), .i_wdata(tx_byte), .i_pop(tx_pop), .o_rdata(tx_head),
        .o_empty(tx_empty), .o_full(tx_full)
    );

    uart_tx uart_tx_inst (
        .i_pll_clk(i_pll_clk), .i_rst(i_rst), .i_baud_div(baud_div),
        .i_empty(tx_empty), .i_byte(tx_head), .o_pop(tx_pop),
        .o_tx_pin(o_tx_pin), .o_drained(tx_drained)
    );

    uart_rx uart_rx_inst (
        .i_pll_clk(i_pll_clk), .i_rst(i_rst), .i_baud_div(baud_div),
        .i_rx_pin(i_rx_pin), .o_strobe(rx_strobe), .o_byte(rx_byte)
    );

endmodule

`default_nettype wire

/* hw/echo_ctrl.sv */
// bus master fsm that programs the uart and echoes received bytes after a delay
`timescale 1ns/1ps
`default_nettype none

module echo_ctrl #(
    parameter int BAUD_DIV     = 469,
    parameter int DELAY_CYCLES = 6_750_000
) (
    input  logic               i_pll_clk,
    input  logic               i_rst,
    output uart_pkg::bus_req_t o_req,
    input  uart_pkg::bus_rsp_t i_rsp
);
    import uart_pkg::*;

    localparam baud_div_t   BAUD_VAL  = baud_div_t'(BAUD_DIV);
    localparam logic [31:0] DELAY_VAL = 32'(DELAY_CYCLES);
    localparam byte_t       INT_ALL   = byte_t'((1 << INT_RX) | (1 << INT_TX));

    echo_state_e state_q;
    echo_state_e ret_q;       // where the bus wait or delay returns to
    bus_req_t    req_q;
    byte_t       rdata_q;
    logic [31:0] delay_q;

    assign o_req = req_q;

    task automatic start_access(input logic wr, input reg_addr_t addr,
                                input byte_t data, input echo_state_e ret);
        req_q.enable <= 1'b1;
        req_q.wr_en  <= wr;
        req_q.addr   <= addr;
        req_q.wdata  <= data;
        ret_q        <= ret;
        state_q      <= ST_BUS_WAIT;
    endtask

    always_ff @(posedge i_pll_clk) begin
        if (!i_rst) begin
            state_q <= ST_INIT;
            ret_q   <= ST_INIT;
            req_q   <= '0;
            delay_q <= '0;
        end else begin
            case (state_q)
                ST_INIT:     start_access(1'b1, ADDR_BAUD_L, BAUD_VAL[7:0], ST_BAUD_H);
                ST_BAUD_H:   start_access(1'b1, ADDR_BAUD_H, BAUD_VAL[15:8], ST_INT_EN);
                ST_INT_EN:   start_access(1'b1, ADDR_INT_EN, INT_ALL, ST_READ_STATUS);
                ST_READ_STATUS: begin
                    start_access(1'b0, ADDR_STATUS, '0, ST_CHECK_STATUS);
                end
                ST_CHECK_STATUS: begin
                    if (rdata_q[ST_RX_AVAIL] && !rdata_q[ST_TX_FULL]) begin
                        delay_q <= DELAY_VAL;
                        ret_q   <= ST_READ_DATA;
                        state_q <= ST_DELAY;
                    end else begin
                        state_q <= ST_READ_STATUS;    // poll again
                    end
                end
                ST_READ_DATA: start_access(1'b0, ADDR_DATA, '0, ST_PAUSE);
                ST_PAUSE: begin                       // keep the led on a while
                    delay_q <= DELAY_VAL;
                    ret_q   <= ST_WRITE_ECHO;
                    state_q <= ST_DELAY;
                end
                ST_WRITE_ECHO: start_access(1'b1, ADDR_DATA, rdata_q, ST_CLEAR_INT);
                ST_CLEAR_INT: begin
                    start_access(1'b1, ADDR_INT_PEND, INT_ALL, ST_READ_STATUS);
                end
                ST_BUS_WAIT: begin
                    if (i_rsp.ready) begin
                        req_q.enable <= 1'b0;
                        req_q.wr_en  <= 1'b0;
                        state_q      <= ret_q;
                    end
                end
                ST_DELAY: begin
                    if (delay_q == '0) begin
                        state_q <= ret_q;
                    end else begin
                        delay_q <= delay_q - 1'b1;
                    end
                end
                default: state_q <= ST_INIT;
            endcase
        end
    end

    always_ff @(posedge i_pll_clk) begin
        if ((state_q == ST_BUS_WAIT) && i_rsp.ready) begin
            rdata_q <= i_rsp.rdata;       // kept for status check and echo
        end
    end

endmodule

`default_nettype wire

/* hw/uart_regs.sv */
// uart register block with bus decode, divisor, interrupt enable and pending, irq
`timescale 1ns/1ps
`default_nettype none

module uart_regs (
    input  logic                i_pll_clk,
    input  logic                i_rst,
    input  uart_pkg::bus_req_t  i_req,
    output uart_pkg::bus_rsp_t  o_rsp,
    output uart_pkg::baud_div_t o_baud_div,
    input  logic                i_rx_empty,
    input  uart_pkg::byte_t     i_rx_byte,
    output logic                o_rx_pop,
    input  logic                i_tx_full,
    output logic                o_tx_push,
    output uart_pkg::byte_t     o_tx_byte,
    input  logic                i_rx_strobe,
    input  logic                i_tx_drained,
    output logic                o_irq
);
    import uart_pkg::*;

    logic      ready_q;
    baud_div_t baud_q;
    int_bits_t int_en_q;
    int_bits_t int_pend_q;
    int_bits_t set_bits;
    int_bits_t clr_bits;
    byte_t     rdata;
    logic      wr_acc;
    logic      rd_acc;

    assign wr_acc = ready_q && i_req.wr_en;     // one effect per access
    assign rd_acc = ready_q && !i_req.wr_en;

    assign o_rx_pop   = rd_acc && (i_req.addr == ADDR_DATA);
    assign o_tx_push  = wr_acc && (i_req.addr == ADDR_DATA);
    assign o_tx_byte  = i_req.wdata;
    assign o_baud_div = baud_q;
    assign o_irq      = |(int_pend_q & int_en_q);
    assign o_rsp      = '{ready: ready_q, rdata: rdata};

    always_comb begin
        set_bits         = '0;
        set_bits[INT_RX] = i_rx_strobe;
        set_bits[INT_TX] = i_tx_drained;
        clr_bits         = '0;
        if (wr_acc && (i_req.addr == ADDR_INT_PEND)) begin
            clr_bits = int_bits_t'(i_req.wdata);
        end
    end

    always_comb begin
        rdata = '0;
        case (i_req.addr)
            ADDR_BAUD_L:   rdata = baud_q[7:0];
            ADDR_BAUD_H:   rdata = baud_q[15:8];
            ADDR_STATUS: begin
                rdata[ST_RX_AVAIL] = !i_rx_empty;
                rdata[ST_TX_FULL]  = i_tx_full;
            end
            ADDR_DATA:     rdata = i_rx_byte;    // fifo head, popped in this cycle
            ADDR_INT_EN:   rdata = byte_t'(int_en_q);
            ADDR_INT_PEND: rdata = byte_t'(int_pend_q);
            default:       rdata = '0;
        endcase
    end

    always_ff @(posedge i_pll_clk) begin
        if (!i_rst) begin
            ready_q    <= 1'b0;
            baud_q     <= '0;      // lines stay quiet until programmed
            int_en_q   <= '0;
            int_pend_q <= '0;
        end else begin
            ready_q    <= i_req.enable && !ready_q;   // enable ignored in ready cycle
            int_pend_q <= (int_pend_q & ~clr_bits) | set_bits;   // set wins
            if (wr_acc) begin
                case (i_req.addr)
                    ADDR_BAUD_L: baud_q[7:0]  <= i_req.wdata;
                    ADDR_BAUD_H: baud_q[15:8] <= i_req.wdata;
                    ADDR_INT_EN: int_en_q     <= int_bits_t'(i_req.wdata);
                    default:     ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hw/uart_rx.sv */
// uart deserializer with input synchronizer, mid-bit sampling and stop bit check
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic                i_pll_clk,
    input  logic                i_rst,
    input  uart_pkg::baud_div_t i_baud_div,
    input  logic                i_rx_pin,
    output logic                o_strobe,
    output uart_pkg::byte_t     o_byte
);
    import uart_pkg::*;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    logic [1:0] sync_q;
    logic       rx_prev_q;
    logic       rx_s;
    logic       fall;
    rx_state_e  state_q;
    baud_div_t  baud_cnt_q;
    baud_div_t  bit_last;
    baud_div_t  half_last;
    logic       half_hit;
    logic       bit_hit;
    logic [2:0] bit_idx_q;
    byte_t      shift_q;
    logic       strobe_q;

    assign rx_s      = sync_q[1];
    assign fall      = rx_prev_q && !rx_s;
    assign bit_last  = i_baud_div - baud_div_t'(1);
    assign half_last = (i_baud_div >> 1) - baud_div_t'(1);
    assign half_hit  = (baud_cnt_q == half_last);
    assign bit_hit   = (baud_cnt_q == bit_last);
    assign o_strobe  = strobe_q;
    assign o_byte    = shift_q;

    always_ff @(posedge i_pll_clk) begin
        if (!i_rst) begin
            sync_q     <= 2'b11;      // line idles high
            rx_prev_q  <= 1'b1;
            state_q    <= RX_IDLE;
            baud_cnt_q <= '0;
            bit_idx_q  <= '0;
            strobe_q   <= 1'b0;
        end else begin
            sync_q    <= {sync_q[0], i_rx_pin};
            rx_prev_q <= rx_s;
            strobe_q  <= 1'b0;
            case (state_q)
                RX_IDLE: begin
                    baud_cnt_q <= '0;
                    if (fall && (i_baud_div != '0)) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    if (half_hit) begin
                        baud_cnt_q <= '0;
                        bit_idx_q  <= '0;
                        state_q    <= rx_s ? RX_IDLE : RX_DATA;   // glitch, not a start bit
                    end else begin
                        baud_cnt_q <= baud_cnt_q + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_hit) begin
                        baud_cnt_q <= '0;
                        bit_idx_q  <= bit_idx_q + 1'b1;
                        if (bit_idx_q == 3'd7) begin
                            state_q <= RX_STOP;
                        end
                    end else begin
                        baud_cnt_q <= baud_cnt_q + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_hit) begin
                        strobe_q <= rx_s;     // low stop bit drops the frame
                        state_q  <= RX_IDLE;
                    end else begin
                        baud_cnt_q <= baud_cnt_q + 1'b1;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_pll_clk) begin
        if ((state_q == RX_DATA) && bit_hit) begin
            shift_q <= {rx_s, shift_q[7:1]};    // lsb arrives first
        end
    end

endmodule

`default_nettype wire

/* hw/uart_tx.sv */
// uart serializer, start bit, eight data bits lsb first, one stop bit
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic                i_pll_clk,
    input  logic                i_rst,
    input  uart_pkg::baud_div_t i_baud_div,
    input  logic                i_empty,
    input  uart_pkg::byte_t     i_byte,
    output logic                o_pop,
    output logic                o_tx_pin,
    output logic                o_drained
);
    import uart_pkg::*;

    localparam int FRAME_BITS = 10;

    logic                  busy_q;
    logic [3:0]            bit_cnt_q;
    logic [FRAME_BITS-1:0] shift_q;     // stop, data, start
    baud_div_t             baud_cnt_q;
    baud_div_t             bit_last;
    logic                  bit_end;
    logic                  frame_end;

    assign bit_last  = i_baud_div - baud_div_t'(1);
    assign bit_end   = busy_q && (baud_cnt_q == bit_last);
    assign frame_end = bit_end && (bit_cnt_q == 4'(FRAME_BITS - 1));

    assign o_pop     = !busy_q && !i_empty && (i_baud_div != '0);
    assign o_tx_pin  = !busy_q || shift_q[0];     // idle high
    assign o_drained = frame_end && i_empty;

    always_ff @(posedge i_pll_clk) begin
        if (!i_rst) begin
            busy_q     <= 1'b0;
            bit_cnt_q  <= '0;
            baud_cnt_q <= '0;
        end else if (o_pop) begin
            busy_q     <= 1'b1;
            bit_cnt_q  <= '0;
            baud_cnt_q <= '0;
        end else if (bit_end) begin
            baud_cnt_q <= '0;
            bit_cnt_q  <= bit_cnt_q + 1'b1;
            if (frame_end) begin
                busy_q <= 1'b0;     // stop bit done
            end
        end else if (busy_q) begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge i_pll_clk) begin
        if (o_pop) begin
            shift_q <= {1'b1, i_byte, 1'b0};
        end else if (bit_end) begin
            shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]};
        end
    end

endmodule

`default_nettype wire

/* hw/byte_fifo.sv */
// synchronous byte fifo with wrap-bit pointers
`timescale 1ns/1ps
`default_nettype none

module byte_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic            i_pll_clk,
    input  logic            i_rst,
    input  logic            i_push,
    input  uart_pkg::byte_t i_wdata,
    input  logic            i_pop,
    output uart_pkg::byte_t o_rdata,
    output logic            o_empty,
    output logic            o_full
);
    import uart_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    byte_t       mem [FIFO_DEPTH];
    logic [AW:0] wr_ptr_q;      // extra msb marks the wrap
    logic [AW:0] rd_ptr_q;
    logic        do_push;
    logic        do_pop;

    assign o_empty = (wr_ptr_q == rd_ptr_q);
    assign o_full  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                     (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);
    assign do_push = i_push && !o_full;     // push on full is dropped
    assign do_pop  = i_pop && !o_empty;
    assign o_rdata = mem[rd_ptr_q[AW-1:0]];   // head shown ahead of the pop

    always_ff @(posedge i_pll_clk) begin
        if (!i_rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge i_pll_clk) begin
        if (do_push) begin
            mem[wr_ptr_q[AW-1:0]] <= i_wdata;
        end
    end

endmodule

`default_nettype wire

/* hw/uart_pkg.sv */
// shared uart types, register map, status and interrupt bits, echo controller states
`default_nettype none

package uart_pkg;

    typedef logic [7:0]  byte_t;        // data byte on bus and in fifos
    typedef logic [15:0] baud_div_t;    // bit period in clock cycles
    typedef logic [2:0]  reg_addr_t;    // register address
    typedef logic [1:0]  int_bits_t;    // one bit per interrupt source

    localparam reg_addr_t ADDR_BAUD_L   = 3'd0;
    localparam reg_addr_t ADDR_BAUD_H   = 3'd1;
    localparam reg_addr_t ADDR_STATUS   = 3'd2;
    localparam reg_addr_t ADDR_DATA     = 3'd3;   // read pops rx, write pushes tx
    localparam reg_addr_t ADDR_INT_EN   = 3'd4;
    localparam reg_addr_t ADDR_INT_PEND = 3'd5;   // write one to clear

    localparam int ST_RX_AVAIL = 0;   // rx fifo not empty
    localparam int ST_TX_FULL  = 1;   // tx fifo full

    localparam int INT_RX = 0;        // byte received
    localparam int INT_TX = 1;        // tx fifo drained

    typedef struct packed {
        logic      enable;    // held until ready
        logic      wr_en;
        reg_addr_t addr;
        byte_t     wdata;
    } bus_req_t;

    typedef struct packed {
        logic  ready;         // single cycle acknowledge
        byte_t rdata;
    } bus_rsp_t;

    typedef enum logic [3:0] {
        ST_INIT,
        ST_BAUD_H,
        ST_INT_EN,
        ST_READ_STATUS,
        ST_CHECK_STATUS,
        ST_READ_DATA,
        ST_PAUSE,
        ST_WRITE_ECHO,
        ST_CLEAR_INT,
        ST_BUS_WAIT,
        ST_DELAY
    } echo_state_e;

endpackage

`default_nettype wire
